/* list.f */
+incdir+verilog
verilog/hwpe_regfile_pkg.sv
verilog/regfile_access_if.sv
verilog/regfile_bus_port.sv
verilog/offload_ctrl.sv
verilog/param_store.sv
verilog/hwpe_regfile_top.sv
test/tb_hwpe_regfile.sv

/* run_sim.sh */
#!/bin/sh
# Builds the HWPE register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hwpe_regfile -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_hwpe_regfile)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

/* test/tb_hwpe_regfile.sv */
/*
 * Testbench for the HWPE control register file
 * Host bus tasks, an engine model and checks of the offload protocol
 */
`timescale 1ns/1ps
`include "hwpe_regfile_params.svh"

module tb_hwpe_regfile;

  localparam int AW  = `HWPE_CXT_W + `HWPE_REG_IDX_W;
  localparam int NC  = `HWPE_N_CONTEXT;
  localparam int NIO = `HWPE_N_IO_REGS;
  localparam int NG  = `HWPE_N_GENERIC_REGS;
  localparam int BW  = `HWPE_N_IO_REGS * `HWPE_DATA_WIDTH;

  localparam logic [AW-1:0] A_TRIGGER   = AW'(`HWPE_REG_TRIGGER);
  localparam logic [AW-1:0] A_ACQUIRE   = AW'(`HWPE_REG_ACQUIRE);
  localparam logic [AW-1:0] A_FINISHED  = AW'(`HWPE_REG_FINISHED);
  localparam logic [AW-1:0] A_STATUS    = AW'(`HWPE_REG_STATUS);
  localparam logic [AW-1:0] A_RUNNING   = AW'(`HWPE_REG_RUNNING);
  localparam logic [AW-1:0] A_SOFTCLEAR = AW'(`HWPE_REG_SOFTCLEAR);
  localparam logic [AW-1:0] A_UNMAPPED  = AW'(6);

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_i;
  logic                          we_i;
  logic [AW-1:0]                 addr_i;
  hwpe_regfile_pkg::data_t       wdata_i;
  logic [`HWPE_DATA_WIDTH/8-1:0] be_i;
  hwpe_regfile_pkg::data_t       rdata_o;
  logic                          done_i;
  logic                          start_o;
  logic [BW-1:0]                 io_params_o;
  logic [NG*`HWPE_DATA_WIDTH-1:0] generic_params_o;

  integer seed = 83579;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_err0 = 0;
  int done_count = 0;  // Completions given by the engine model
  int pending = 0;
  int served = 0;
  int allowed = 0;     // Number of jobs the engine may run
  int delay = 0;
  int exp_running = 0;
  int exp_offload = 0;
  hwpe_regfile_pkg::data_t status_exp = '0;
  hwpe_regfile_pkg::data_t io_exp [NC][NIO];
  hwpe_regfile_pkg::data_t gen_exp [NG];

  hwpe_regfile_top i_hwpe_regfile_top (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .rdata_o,
    .done_i, .start_o, .io_params_o, .generic_params_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Engine model that queues starts and gives each job a random run time
  initial begin
    done_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      done_i <= 1'b0;
      if (start_o) pending++;
      if (delay > 0) begin
        delay--;
        if (delay == 0) begin
          done_i <= 1'b1;
          done_count++;
        end
      end else if (pending > 0 && served < allowed) begin
        pending--;
        served++;
        delay = 4 + ($random(seed) & 7);  // Run time of 4 to 11 cycles
      end
    end
  end

  function automatic hwpe_regfile_pkg::data_t merge_bytes(hwpe_regfile_pkg::data_t old_w,
                                                          hwpe_regfile_pkg::data_t new_w,
                                                          logic [3:0] be);
    hwpe_regfile_pkg::data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [AW-1:0] io_addr(input int c, input int r);
    return {`HWPE_CXT_W'(c), `HWPE_REG_IDX_W'(`HWPE_REG_IO_BASE + r)};
  endfunction

  function automatic logic [AW-1:0] gen_addr(input int g);
    return AW'(`HWPE_REG_GENERIC_BASE + g);
  endfunction

  function automatic logic [BW-1:0] bank_of(input int c);
    logic [BW-1:0] bank;
    for (int r = 0; r < NIO; r++) bank[r*32 +: 32] = io_exp[c][r];
    return bank;
  endfunction

  task automatic check_word(input string name, input hwpe_regfile_pkg::data_t got,
                            input hwpe_regfile_pkg::data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bank(input string name, input logic [BW-1:0] got,
                            input logic [BW-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %-20s %s", tests, name, (errors == test_err0) ? "ok" : "with errors");
    test_err0 = errors;
  endtask

  // Request held for one cycle and accepted at the next edge
  task automatic bus_write(input logic [AW-1:0] addr, input hwpe_regfile_pkg::data_t data,
                           input logic [3:0] be);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    be_i    <= be;
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic bus_read(input logic [AW-1:0] addr, output hwpe_regfile_pkg::data_t data);
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= addr;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    data = rdata_o;  // Registered one cycle after the request
  endtask

  task automatic wait_dones(input int n);
    int cycles;
    cycles = 0;
    while (done_count < n && cycles < 200) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_count < n) begin
      errors++;
      $display("Timed out at %0t ns waiting for engine completion %0d", $time, n);
    end
    repeat (3) @(posedge clk_i);  // Running id lags done by two edges
  endtask

  task automatic trigger_job(input int job);
    hwpe_regfile_pkg::data_t v;
    bus_write(A_TRIGGER, '0, 4'hF);
    check_word("start_o", 32'(start_o), 32'd1);
    @(negedge clk_i);
    check_word("start_o", 32'(start_o), 32'd0);
    status_exp[(job % NC)*8 +: 8] = 8'h01;
    bus_read(A_STATUS, v);
    check_word("STATUS", v, status_exp);
  endtask

  task automatic complete_job();
    hwpe_regfile_pkg::data_t v;
    allowed = exp_running + 1;
    wait_dones(exp_running + 1);
    status_exp[(exp_running % NC)*8 +: 8] = 8'h00;
    exp_running++;
    bus_read(A_STATUS, v);
    check_word("STATUS", v, status_exp);
    bus_read(A_RUNNING, v);
    check_word("RUNNING", v, 32'(exp_running));
    check_bank("io_params_o", io_params_o, bank_of(exp_running % NC));
  endtask

  task automatic acquire(input hwpe_regfile_pkg::data_t exp);
    hwpe_regfile_pkg::data_t v;
    bus_read(A_ACQUIRE, v);
    check_word("ACQUIRE", v, exp);
  endtask

  task automatic check_params();
    hwpe_regfile_pkg::data_t v;
    for (int c = 0; c < NC; c++) begin
      for (int r = 0; r < NIO; r++) begin
        bus_read(io_addr(c, r), v);
        check_word($sformatf("io[%0d][%0d]", c, r), v, io_exp[c][r]);
      end
    end
    for (int g = 0; g < NG; g++) begin
      bus_read(gen_addr(g), v);
      check_word($sformatf("generic[%0d]", g), v, gen_exp[g]);
    end
    for (int g = 0; g < NG; g++) begin
      check_word($sformatf("generic_params_o[%0d]", g),
                 generic_params_o[g*`HWPE_DATA_WIDTH +: `HWPE_DATA_WIDTH], gen_exp[g]);
    end
  endtask

  initial begin
    hwpe_regfile_pkg::data_t v;
    hwpe_regfile_pkg::data_t w;
    logic [3:0] be;
    req_i   <= 1'b0;
    we_i    <= 1'b0;
    addr_i  <= '0;
    wdata_i <= '0;
    be_i    <= '0;
    rst_ni  <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    check_word("rdata_o", rdata_o, '0);
    check_word("start_o", 32'(start_o), '0);
    bus_read(A_STATUS, v);
    check_word("STATUS", v, '0);
    bus_read(A_RUNNING, v);
    check_word("RUNNING", v, '0);
    bus_read(A_FINISHED, v);
    check_word("FINISHED", v, '0);
    bus_read(A_UNMAPPED, v);
    check_word("unmapped", v, `HWPE_RDATA_UNMAPPED);
    end_test("reset values");

    // Engine held idle so both contexts stay busy
    acquire(32'd0);
    acquire(`HWPE_RESP_OFFLOADING);
    trigger_job(0);
    acquire(32'd1);
    trigger_job(1);
    acquire(`HWPE_RESP_ALL_BUSY);
    exp_offload = 2;
    end_test("acquire responses");

    for (int c = 0; c < NC; c++) begin
      for (int r = 0; r < NIO; r++) begin
        w = $random(seed);
        bus_write(io_addr(c, r), w, 4'hF);
        io_exp[c][r] = w;
        w  = $random(seed);
        be = 4'($random(seed));
        bus_write(io_addr(c, r), w, be);  // Partial byte enables merge into the word
        io_exp[c][r] = merge_bytes(io_exp[c][r], w, be);
      end
    end
    for (int g = 0; g < NG; g++) begin
      gen_exp[g] = $random(seed);
      bus_write(gen_addr(g), gen_exp[g], 4'hF);
    end
    check_params();
    end_test("parameter storage");

    check_bank("io_params_o", io_params_o, bank_of(0));
    complete_job();
    complete_job();
    end_test("job completion");

    bus_read(A_FINISHED, v);
    check_word("FINISHED", v, 32'd2);
    for (int j = 0; j < 3; j++) begin
      acquire(32'(exp_offload));
      trigger_job(exp_offload);
      exp_offload++;
      complete_job();
    end
    bus_read(A_FINISHED, v);
    check_word("FINISHED", v, 32'd2);
    bus_read(A_FINISHED, v);
    check_word("FINISHED", v, 32'd0);
    end_test("finished counter");

    bus_write(A_SOFTCLEAR, '0, 4'hF);
    foreach (io_exp[c, r]) io_exp[c][r] = '0;
    foreach (gen_exp[g]) gen_exp[g] = '0;
    check_params();
    check_bank("io_params_o", io_params_o, '0);
    bus_read(A_STATUS, v);
    check_word("STATUS", v, '0);
    bus_read(A_RUNNING, v);
    check_word("RUNNING", v, '0);
    bus_read(A_FINISHED, v);
    check_word("FINISHED", v, '0);
    acquire(32'd0);
    end_test("soft clear");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verilog/hwpe_regfile_top.sv */
/*
 * HWPE control register file
 * Host register bus on one side, engine start, done and parameters on the other
 */
`timescale 1ns/1ps
`include "hwpe_regfile_params.svh"

module hwpe_regfile_top (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Host register bus
  input  logic                                             req_i,
  input  logic                                             we_i,
  input  logic [`HWPE_CXT_W+`HWPE_REG_IDX_W-1:0]           addr_i,
  input  hwpe_regfile_pkg::data_t                          wdata_i,
  input  logic [`HWPE_DATA_WIDTH/8-1:0]                    be_i,
  output hwpe_regfile_pkg::data_t                          rdata_o,
  // Engine side
  input  logic                                             done_i,
  output logic                                             start_o,
  output logic [`HWPE_N_IO_REGS*`HWPE_DATA_WIDTH-1:0]      io_params_o,
  output logic [`HWPE_N_GENERIC_REGS*`HWPE_DATA_WIDTH-1:0] generic_params_o
);

  logic [`HWPE_CXT_W-1:0] running_cxt;  // From the running job id

  regfile_access_if acc_if ();

  regfile_bus_port i_regfile_bus_port (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .addr_i  ( addr_i  ),
    .wdata_i ( wdata_i ),
    .be_i    ( be_i    ),
    .rdata_o ( rdata_o ),
    .acc     ( acc_if  )
  );

  offload_ctrl i_offload_ctrl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .done_i        ( done_i      ),
    .start_o       ( start_o     ),
    .running_cxt_o ( running_cxt ),
    .acc           ( acc_if      )
  );

  param_store i_param_store (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .acc              ( acc_if           ),
    .running_cxt_i    ( running_cxt      ),
    .io_params_o      ( io_params_o      ),
    .generic_params_o ( generic_params_o )
  );

endmodule

/* verilog/param_store.sv */
/*
 * Parameter store
 * Generic words and per-context I/O words with byte-enable writes
 */
`timescale 1ns/1ps
`include "hwpe_regfile_params.svh"

module param_store (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  regfile_access_if.store                              acc,
  input  logic [`HWPE_CXT_W-1:0]                       running_cxt_i,
  output logic [`HWPE_N_IO_REGS*`HWPE_DATA_WIDTH-1:0]  io_params_o,
  output logic [`HWPE_N_GENERIC_REGS*`HWPE_DATA_WIDTH-1:0] generic_params_o
);

  localparam int IW = `HWPE_REG_IDX_W;
  localparam int CW = `HWPE_CXT_W;
  localparam int NB = `HWPE_DATA_WIDTH/8;

  hwpe_regfile_pkg::data_t [`HWPE_N_GENERIC_REGS-1:0]                  generic_q;
  hwpe_regfile_pkg::data_t [`HWPE_N_CONTEXT-1:0][`HWPE_N_IO_REGS-1:0] io_q;
  logic                                                                store_wr;

  function automatic hwpe_regfile_pkg::data_t be_merge(hwpe_regfile_pkg::data_t old_w,
                                                       hwpe_regfile_pkg::data_t new_w,
                                                       logic [NB-1:0] be);
    hwpe_regfile_pkg::data_t merged;
    merged = old_w;
    for (int b = 0; b < NB; b++) begin
      if (be[b]) merged[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return merged;
  endfunction

  assign store_wr = acc.wr && (acc.kind == hwpe_regfile_pkg::ACC_STORE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      generic_q <= '0;
      io_q      <= '0;
    end else if (acc.soft_clear) begin
      generic_q <= '0;
      io_q      <= '0;
    end else if (store_wr) begin
      for (int g = 0; g < `HWPE_N_GENERIC_REGS; g++) begin
        if (acc.reg_idx == IW'(`HWPE_REG_GENERIC_BASE + g))
          generic_q[g] <= be_merge(generic_q[g], acc.wdata, acc.be);
      end
      for (int c = 0; c < `HWPE_N_CONTEXT; c++) begin
        for (int r = 0; r < `HWPE_N_IO_REGS; r++) begin
          if (acc.cxt == CW'(c) && acc.reg_idx == IW'(`HWPE_REG_IO_BASE + r))
            io_q[c][r] <= be_merge(io_q[c][r], acc.wdata, acc.be);
        end
      end
    end
  end

  // Read mux with I/O words taken from the addressed context
  always_comb begin
    acc.store_rdata = '0;
    for (int g = 0; g < `HWPE_N_GENERIC_REGS; g++) begin
      if (acc.reg_idx == IW'(`HWPE_REG_GENERIC_BASE + g)) acc.store_rdata = generic_q[g];
    end
    for (int r = 0; r < `HWPE_N_IO_REGS; r++) begin
      if (acc.reg_idx == IW'(`HWPE_REG_IO_BASE + r)) acc.store_rdata = io_q[acc.cxt][r];
    end
  end

  assign io_params_o      = io_q[running_cxt_i];  // Bank of the job on the engine
  assign generic_params_o = generic_q;

endmodule

/* verilog/offload_ctrl.sv */
/*
 * Offload controller
 * Job id counters, context status, critical flag and finished counter
 */
`timescale 1ns/1ps
`include "hwpe_regfile_params.svh"

module offload_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   done_i,
  output logic                   start_o,
  output logic [`HWPE_CXT_W-1:0] running_cxt_o,
  regfile_access_if.ctrl         acc
);

  localparam int JW = `HWPE_JOB_ID_W;
  localparam int CW = `HWPE_CXT_W;
  localparam int NC = `HWPE_N_CONTEXT;

  logic [JW-1:0]         offload_id_q;
  logic [JW-1:0]         running_id_q;
  logic                  running_incr_q;
  logic [CW-1:0]         pointer_cxt_q;   // Context of the last granted job
  logic [NC-1:0][7:0]    status_q;
  logic                  critical_q;
  logic [1:0]            finished_cnt_q;

  logic [NC-1:0]           busy;
  logic                    acquire;
  logic                    grant;
  logic                    trigger;
  logic                    finished_rd;
  hwpe_regfile_pkg::data_t acquire_resp;
  hwpe_regfile_pkg::data_t status_word;

  assign running_cxt_o = running_id_q[CW-1:0];

  assign acquire     = acc.rd && (acc.kind == hwpe_regfile_pkg::ACC_ACQUIRE);
  assign trigger     = acc.wr && (acc.kind == hwpe_regfile_pkg::ACC_TRIGGER);
  assign finished_rd = acc.rd && (acc.kind == hwpe_regfile_pkg::ACC_FINISHED);
  assign grant       = acquire && !critical_q && !(&busy);

  always_comb begin
    status_word = '0;
    for (int i = 0; i < NC; i++) begin
      busy[i]               = |status_q[i];
      status_word[i*8 +: 8] = status_q[i];
    end
  end

  // Open acquire first, then full contexts, else the job id
  always_comb begin
    if (critical_q)   acquire_resp = `HWPE_RESP_OFFLOADING;
    else if (&busy)   acquire_resp = `HWPE_RESP_ALL_BUSY;
    else              acquire_resp = hwpe_regfile_pkg::data_t'(offload_id_q);
  end

  always_comb begin
    case (acc.kind)
      hwpe_regfile_pkg::ACC_ACQUIRE:  acc.mand_rdata = acquire_resp;
      hwpe_regfile_pkg::ACC_FINISHED: acc.mand_rdata = hwpe_regfile_pkg::data_t'(finished_cnt_q);
      hwpe_regfile_pkg::ACC_STATUS:   acc.mand_rdata = status_word;
      hwpe_regfile_pkg::ACC_RUNNING:  acc.mand_rdata = hwpe_regfile_pkg::data_t'(running_id_q);
      default:                        acc.mand_rdata = '0;
    endcase
  end

  // Job id counters with the running id one cycle behind done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q   <= '0;
      running_id_q   <= '0;
      running_incr_q <= 1'b0;
      pointer_cxt_q  <= '0;
    end else if (acc.soft_clear) begin
      offload_id_q   <= '0;
      running_id_q   <= '0;
      running_incr_q <= 1'b0;
      pointer_cxt_q  <= '0;
    end else begin
      running_incr_q <= done_i;
      if (running_incr_q) running_id_q <= running_id_q + 1'b1;
      if (grant) begin
        offload_id_q  <= offload_id_q + 1'b1;
        pointer_cxt_q <= offload_id_q[CW-1:0];
      end
    end
  end

  // Status bytes where trigger wins over done on its own context
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else if (acc.soft_clear) begin
      status_q <= '0;
    end else begin
      for (int i = 0; i < NC; i++) begin
        if (trigger && pointer_cxt_q == CW'(i)) status_q[i] <= 8'h01;
        else if (done_i && running_cxt_o == CW'(i)) status_q[i] <= 8'h00;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      critical_q     <= 1'b0;
      finished_cnt_q <= '0;
      start_o        <= 1'b0;
    end else if (acc.soft_clear) begin
      critical_q     <= 1'b0;
      finished_cnt_q <= '0;
      start_o        <= 1'b0;
    end else begin
      start_o <= trigger;
      if (grant)        critical_q <= 1'b1;
      else if (trigger) critical_q <= 1'b0;
      // Clear on read and saturate at 2
      if (finished_rd)                          finished_cnt_q <= '0;
      else if (done_i && finished_cnt_q < 2'd2) finished_cnt_q <= finished_cnt_q + 1'b1;
    end
  end

endmodule

/* verilog/regfile_bus_port.sv */
/*
 * Register bus port
 * Decodes host accesses, raises soft clear and registers the read data
 */
`timescale 1ns/1ps
`include "hwpe_regfile_params.svh"

module regfile_bus_port (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  logic [`HWPE_CXT_W+`HWPE_REG_IDX_W-1:0] addr_i,
  input  hwpe_regfile_pkg::data_t                 wdata_i,
  input  logic [`HWPE_DATA_WIDTH/8-1:0]           be_i,
  output hwpe_regfile_pkg::data_t                 rdata_o,
  regfile_access_if.bus                           acc
);

  localparam int IW = `HWPE_REG_IDX_W;

  // Window bounds with the end entry exclusive
  localparam logic [IW-1:0] GEN_FIRST = IW'(`HWPE_REG_GENERIC_BASE);
  localparam logic [IW-1:0] GEN_END   = IW'(`HWPE_REG_GENERIC_BASE + `HWPE_N_GENERIC_REGS);
  localparam logic [IW-1:0] IO_FIRST  = IW'(`HWPE_REG_IO_BASE);
  localparam logic [IW-1:0] IO_END    = IW'(`HWPE_REG_IO_BASE + `HWPE_N_IO_REGS);

  logic [IW-1:0]                  reg_idx;
  hwpe_regfile_pkg::access_kind_e kind;
  logic                           wr;
  logic                           rd;
  logic                           soft_clear_q;

  assign reg_idx = addr_i[IW-1:0];
  assign wr      = req_i & we_i;
  assign rd      = req_i & ~we_i;

  // Index decode
  always_comb begin
    kind = hwpe_regfile_pkg::ACC_UNMAPPED;
    if ((reg_idx >= IO_FIRST && reg_idx < IO_END) ||
        (reg_idx >= GEN_FIRST && reg_idx < GEN_END)) begin
      kind = hwpe_regfile_pkg::ACC_STORE;
    end else begin
      case (reg_idx)
        IW'(`HWPE_REG_TRIGGER):   kind = hwpe_regfile_pkg::ACC_TRIGGER;
        IW'(`HWPE_REG_ACQUIRE):   kind = hwpe_regfile_pkg::ACC_ACQUIRE;
        IW'(`HWPE_REG_FINISHED):  kind = hwpe_regfile_pkg::ACC_FINISHED;
        IW'(`HWPE_REG_STATUS):    kind = hwpe_regfile_pkg::ACC_STATUS;
        IW'(`HWPE_REG_RUNNING):   kind = hwpe_regfile_pkg::ACC_RUNNING;
        IW'(`HWPE_REG_SOFTCLEAR): kind = hwpe_regfile_pkg::ACC_SOFTCLEAR;
        default:                  kind = hwpe_regfile_pkg::ACC_UNMAPPED;  // 6, 7 and gaps
      endcase
    end
  end

  // Soft clear pulse and read data register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soft_clear_q <= 1'b0;
      rdata_o      <= '0;
    end else begin
      soft_clear_q <= wr && (kind == hwpe_regfile_pkg::ACC_SOFTCLEAR);
      if (soft_clear_q) begin
        rdata_o <= '0;
      end else if (rd) begin
        case (kind)
          hwpe_regfile_pkg::ACC_STORE:    rdata_o <= acc.store_rdata;
          hwpe_regfile_pkg::ACC_UNMAPPED: rdata_o <= `HWPE_RDATA_UNMAPPED;
          default:                        rdata_o <= acc.mand_rdata;
        endcase
      end
    end
  end

  assign acc.wr         = wr;
  assign acc.rd         = rd;
  assign acc.kind       = kind;
  assign acc.reg_idx    = reg_idx;
  assign acc.cxt        = addr_i[IW +: `HWPE_CXT_W];
  assign acc.wdata      = wdata_i;
  assign acc.be         = be_i;
  assign acc.soft_clear = soft_clear_q;

endmodule

/* verilog/regfile_access_if.sv */
/*
 * Register file access interface
 * One decoded bus access and the read data returned by each block
 */
`timescale 1ns/1ps
`include "hwpe_regfile_params.svh"

interface regfile_access_if;

  logic                            wr;          // One-cycle write strobe
  logic                            rd;          // One-cycle read strobe
  hwpe_regfile_pkg::access_kind_e  kind;
  logic [`HWPE_REG_IDX_W-1:0]      reg_idx;
  logic [`HWPE_CXT_W-1:0]          cxt;
  hwpe_regfile_pkg::data_t         wdata;
  logic [`HWPE_DATA_WIDTH/8-1:0]   be;
  logic                            soft_clear;  // Registered after a SOFTCLEAR write

  // Combinational read values
  hwpe_regfile_pkg::data_t         mand_rdata;
  hwpe_regfile_pkg::data_t         store_rdata;

  modport bus   (output wr, rd, kind, reg_idx, cxt, wdata, be, soft_clear,
                 input  mand_rdata, store_rdata);
  modport ctrl  (input  wr, rd, kind, soft_clear, output mand_rdata);
  modport store (input  wr, kind, reg_idx, cxt, wdata, be, soft_clear,
                 output store_rdata);

endinterface

/* verilog/hwpe_regfile_pkg.sv */
/*
 * HWPE register file package
 * Bus word type and the decoded access kinds
 */
`include "hwpe_regfile_params.svh"

package hwpe_regfile_pkg;

  // One word on the register bus
  typedef logic [`HWPE_DATA_WIDTH-1:0] data_t;

  // Kind of register addressed by a bus access
  typedef enum logic [2:0] {
    ACC_TRIGGER   = 3'd0,  // Start the acquired job
    ACC_ACQUIRE   = 3'd1,  // Test-and-set of a job slot
    ACC_FINISHED  = 3'd2,  // Clear-on-read completion counter
    ACC_STATUS    = 3'd3,  // One busy byte per context
    ACC_RUNNING   = 3'd4,  // Job id on the engine
    ACC_SOFTCLEAR = 3'd5,  // Block-wide clear
    ACC_STORE     = 3'd6,  // Generic or I/O parameter word
    ACC_UNMAPPED  = 3'd7
  } access_kind_e;

endpackage

/* verilog/hwpe_regfile_params.svh */
/*
 * HWPE register file parameters
 * Sizes, register offsets and acquire response codes
 */
`ifndef HWPE_REGFILE_PARAMS_SVH
`define HWPE_REGFILE_PARAMS_SVH

`define HWPE_DATA_WIDTH      32
`define HWPE_N_CONTEXT       2   // Power of two
`define HWPE_N_IO_REGS       4
`define HWPE_N_GENERIC_REGS  4
`define HWPE_REG_IDX_W       5
`define HWPE_CXT_W           1   // Context field sits above the register index
`define HWPE_JOB_ID_W        8

// Register offsets
`define HWPE_REG_TRIGGER      0
`define HWPE_REG_ACQUIRE      1
`define HWPE_REG_FINISHED     2
`define HWPE_REG_STATUS       3
`define HWPE_REG_RUNNING      4
`define HWPE_REG_SOFTCLEAR    5
`define HWPE_REG_GENERIC_BASE 8
`define HWPE_REG_IO_BASE      16

`define HWPE_RESP_OFFLOADING 32'hFFFF_FFFE  // -2
`define HWPE_RESP_ALL_BUSY   32'hFFFF_FFFF  // -1
`define HWPE_RDATA_UNMAPPED  32'hDEAD_BEEF

`endif
